// ==== design/boardPkg.sv ====
package boardPkg;

  // raster size of the display
  localparam int screenWidth  = 320;
  localparam int screenHeight = 240;

  // coordinate port widths
  localparam int xWidth = 9;             // covers 0..319
  localparam int yWidth = 8;             // covers 0..239

  // board placement and block geometry
  localparam int boardOrigin   = 12;     // offset of block 0, both axes
  localparam int blockPitch    = 36;     // block edge in pixels
  localparam int boardBlocks   = 6;      // blocks per side
  localparam int blockIdxWidth = 3;      // column or row index 0..5

  // ring markers
  localparam int numMarkers = 2;         // also the generate count

  // map table
  localparam int numMaps     = 5;        // valid maps 0..4
  localparam int mapSelWidth = 3;        // 5..7 decode as empty

  // two-bit colour codes
  localparam int colorWidth = 2;
  localparam logic [colorWidth-1:0] colorBackground = 2'd0;
  localparam logic [colorWidth-1:0] colorGrid       = 2'd1;
  localparam logic [colorWidth-1:0] colorMarker     = 2'd2;

  // code 3 is unused, composer never emits it

endpackage

// ==== design/pixelScanner.sv ====
module pixelScanner
  import boardPkg::*;
(
  input  logic              clk,
  input  logic              reset,
  output logic [xWidth-1:0] scanX,      // current column
  output logic [yWidth-1:0] scanY,      // current row
  output logic              scanValid,  // level, high once running
  output logic              scanFrame   // one cycle, on pixel (0,0)
);

  logic lastX;  // end of a line
  logic lastY;  // bottom line of the frame

  assign lastX = (scanX == xWidth'(screenWidth - 1));
  assign lastY = (scanY == yWidth'(screenHeight - 1));

  // one pixel per clock, no stalls
  always_ff @(posedge clk) begin
    if (reset) begin
      scanX     <= '0;
      scanY     <= '0;
      scanValid <= 1'b0;
      scanFrame <= 1'b0;
    end else begin
      scanValid <= 1'b1;
      if (!scanValid) begin
        // first valid pixel after reset sits at the origin
        scanFrame <= 1'b1;
      end else begin
        scanFrame <= lastX && lastY;  // next pixel wraps to (0,0)
        if (lastX) begin
          scanX <= '0;
          if (lastY) begin
            scanY <= '0;              // frame wrap
          end else begin
            scanY <= scanY + 1'b1;    // next line
          end
        end else begin
          scanX <= scanX + 1'b1;
        end
      end
    end
  end

endmodule

// ==== design/markerMapRom.sv ====
module markerMapRom
  import boardPkg::*;
(
  input  logic                                      clk,
  input  logic                                      reset,
  input  logic [mapSelWidth-1:0]                    mapSelect,
  input  logic                                      scanFrame,
  output logic [numMarkers-1:0][blockIdxWidth-1:0]  blockCol,
  output logic [numMarkers-1:0][blockIdxWidth-1:0]  blockRow,
  output logic [numMarkers-1:0]                     markerEnable
);

  logic [mapSelWidth-1:0] mapLatched;  // map in force for this frame
  logic [mapSelWidth-1:0] mapCur;      // map used for the current pixel

  // sample only at frame start so a frame never mixes two maps
  always_ff @(posedge clk) begin
    if (reset) begin
      mapLatched <= '0;
    end else if (scanFrame) begin
      mapLatched <= mapSelect;
    end
  end

  // the frame start pixel itself already sees the new map
  assign mapCur = scanFrame ? mapSelect : mapLatched;

  // block positions per map, (col,row)
  always_comb begin
    blockCol = '0;
    blockRow = '0;
    markerEnable = {numMarkers{mapCur < numMaps}};  // 5..7 are empty
    case (mapCur)
      3'd0: begin
        blockCol[0] = 3'd0;  blockRow[0] = 3'd3;
        blockCol[1] = 3'd5;  blockRow[1] = 3'd4;
      end
      3'd1: begin
        blockCol[0] = 3'd1;  blockRow[0] = 3'd4;
        blockCol[1] = 3'd4;  blockRow[1] = 3'd2;
      end
      3'd2: begin
        blockCol[0] = 3'd0;  blockRow[0] = 3'd2;
        blockCol[1] = 3'd2;  blockRow[1] = 3'd2;
      end
      3'd3: begin
        blockCol[0] = 3'd5;  blockRow[0] = 3'd5;
        blockCol[1] = 3'd5;  blockRow[1] = 3'd2;
      end
      3'd4: begin
        blockCol[0] = 3'd1;  blockRow[0] = 3'd3;
        blockCol[1] = 3'd2;  blockRow[1] = 3'd0;
      end
      default: begin
        // positions stay zero, enable is already low
      end
    endcase
  end

endmodule

// ==== design/circleMarker.sv ====
module circleMarker
  import boardPkg::*;
(
  input  logic                     clk,
  input  logic                     reset,
  input  logic [xWidth-1:0]        scanX,
  input  logic [yWidth-1:0]        scanY,
  input  logic                     scanValid,
  input  logic [blockIdxWidth-1:0] blockCol,
  input  logic [blockIdxWidth-1:0] blockRow,
  input  logic                     markerEnable,
  output logic                     markerHit
);

  logic [xWidth-1:0] originX;  // top left of the marker block
  logic [yWidth-1:0] originY;
  logic [xWidth-1:0] dx;       // pixel offset inside the block
  logic [yWidth-1:0] dy;
  logic              inBlock;  // pixel falls inside this block
  logic              ringNow;  // unregistered ring decision

  // ring outline test on in-block offsets 0..35
  // folded to one quadrant since the outline mirrors about 17.5
  function automatic logic onRing(input int ox, input int oy);
    int fx;
    int fy;
    fx = (ox > blockPitch / 2 - 1) ? blockPitch - 1 - ox : ox;
    fy = (oy > blockPitch / 2 - 1) ? blockPitch - 1 - oy : oy;
    onRing = 1'b0;
    case (fy)
      3:       onRing = (fx >= 14);               // top arc, 14..17
      4:       onRing = (fx >= 11 && fx <= 13);
      5:       onRing = (fx >= 9 && fx <= 10);
      6:       onRing = (fx == 8);
      7:       onRing = (fx == 7);
      8:       onRing = (fx == 6);
      9, 10:   onRing = (fx == 5);
      11, 12, 13: onRing = (fx == 4);
      14, 15, 16, 17: onRing = (fx == 3);          // flat side
      default: onRing = 1'b0;                     // rows 0..2 are empty
    endcase
    return onRing;
  endfunction

  assign originX = xWidth'(boardOrigin + blockPitch * int'(blockCol));
  assign originY = yWidth'(boardOrigin + blockPitch * int'(blockRow));

  // offsets wrap to large values left of or above the block
  assign dx = scanX - originX;
  assign dy = scanY - originY;

  assign inBlock = (scanX >= originX) && (scanY >= originY)
                && (int'(dx) < blockPitch) && (int'(dy) < blockPitch);

  assign ringNow = scanValid && markerEnable && inBlock && onRing(int'(dx), int'(dy));

  // one cycle, matched by the composer delay stage
  always_ff @(posedge clk) begin
    if (reset) begin
      markerHit <= 1'b0;
    end else begin
      markerHit <= ringNow;
    end
  end

endmodule

// ==== design/pixelComposer.sv ====
module pixelComposer
  import boardPkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  input  logic [xWidth-1:0]     scanX,
  input  logic [yWidth-1:0]     scanY,
  input  logic                  scanValid,
  input  logic                  scanFrame,
  input  logic [numMarkers-1:0] markerHit,
  output logic [xWidth-1:0]     pixelX,
  output logic [yWidth-1:0]     pixelY,
  output logic                  pixelValid,
  output logic                  frameStart,
  output logic [colorWidth-1:0] pixelColor
);

  logic [xWidth-1:0]     xD;      // coords aligned with markerHit
  logic [yWidth-1:0]     yD;
  logic                  validD;
  logic                  frameD;
  logic                  onGrid;  // pixel on a block border
  logic [colorWidth-1:0] colorNext;

  // coordinate sits on one of the 7 border lines
  function automatic logic onLine(input int a);
    onLine = 1'b0;
    for (int k = 0; k <= boardBlocks; k++) begin
      if (a == boardOrigin + k * blockPitch) onLine = 1'b1;
    end
    return onLine;
  endfunction

  // coordinate within the board extent 12..228
  function automatic logic inSpan(input int a);
    return (a >= boardOrigin) && (a <= boardOrigin + boardBlocks * blockPitch);
  endfunction

  always_ff @(posedge clk) begin
    xD <= scanX;  // one cycle behind the scanner
    yD <= scanY;
    if (reset) begin
      validD <= 1'b0;
      frameD <= 1'b0;
    end else begin
      validD <= scanValid;
      frameD <= scanFrame;
    end
  end

  // vertical lines then horizontal lines
  assign onGrid = (onLine(int'(xD)) && inSpan(int'(yD)))
               || (onLine(int'(yD)) && inSpan(int'(xD)));

  // priority marker > grid > background
  always_comb begin
    if (!validD)         colorNext = colorBackground;
    else if (|markerHit) colorNext = colorMarker;
    else if (onGrid)     colorNext = colorGrid;
    else                 colorNext = colorBackground;
  end

  always_ff @(posedge clk) begin
    pixelX <= xD;
    pixelY <= yD;
    if (reset) begin
      pixelValid <= 1'b0;
      frameStart <= 1'b0;
      pixelColor <= colorBackground;
    end else begin
      pixelValid <= validD;
      frameStart <= frameD;
      pixelColor <= colorNext;
    end
  end

endmodule

// ==== design/boardRenderer.sv ====
module boardRenderer
  import boardPkg::*;
(
  input  logic                   clk,
  input  logic                   reset,
  input  logic [mapSelWidth-1:0] mapSelect,   // sampled at frame start
  output logic [xWidth-1:0]      pixelX,
  output logic [yWidth-1:0]      pixelY,
  output logic                   pixelValid,
  output logic                   frameStart,
  output logic [colorWidth-1:0]  pixelColor
);

  logic [xWidth-1:0]                      scanX;
  logic [yWidth-1:0]                      scanY;
  logic                                   scanValid;
  logic                                   scanFrame;
  logic [numMarkers-1:0][blockIdxWidth-1:0] blockCol;  // per marker
  logic [numMarkers-1:0][blockIdxWidth-1:0] blockRow;
  logic [numMarkers-1:0]                  markerEnable;
  logic [numMarkers-1:0]                  markerHit;   // one bit per ring

  pixelScanner scanner (
    .clk, .reset,
    .scanX, .scanY, .scanValid, .scanFrame
  );

  markerMapRom mapRom (
    .clk, .reset, .mapSelect, .scanFrame,
    .blockCol, .blockRow, .markerEnable
  );

  // one ring generator per marker
  for (genvar i = 0; i < numMarkers; i++) begin : genMarker
    circleMarker marker (
      .clk, .reset,
      .scanX, .scanY, .scanValid,
      .blockCol     (blockCol[i]),
      .blockRow     (blockRow[i]),
      .markerEnable (markerEnable[i]),
      .markerHit    (markerHit[i])
    );
  end

  pixelComposer composer (
    .clk, .reset,
    .scanX, .scanY, .scanValid, .scanFrame, .markerHit,
    .pixelX, .pixelY, .pixelValid, .frameStart, .pixelColor
  );

endmodule

// ==== sim/renderCases.svh ====
// per row name, map select, x, y, expected colour
// rows of one map kept in scan order so each wait stays short

// map 0, markers in blocks (0,3) and (5,4)
addCase("m0 grid row line",   3'd0, 9'd12,  8'd12,  colorGrid);
addCase("m0 grid horizontal", 3'd0, 9'd100, 8'd48,  colorGrid);
addCase("m0 empty block",     3'd0, 9'd98,  8'd87,  colorBackground);  // block (2,2)
addCase("m0 grid vertical",   3'd0, 9'd48,  8'd100, colorGrid);
addCase("m0 right of board",  3'd0, 9'd300, 8'd100, colorBackground);
addCase("m0 ring top",        3'd0, 9'd26,  8'd123, colorMarker);      // dx 14 dy 3
addCase("m0 ring left",       3'd0, 9'd15,  8'd137, colorMarker);      // dx 3 dy 17
addCase("m0 inside ring",     3'd0, 9'd16,  8'd137, colorBackground);  // dx 4
addCase("m0 ring centre",     3'd0, 9'd29,  8'd137, colorBackground);
addCase("m0 m1 ring right",   3'd0, 9'd224, 8'd176, colorMarker);      // dx 32 dy 20
addCase("m0 m1 ring bottom",  3'd0, 9'd213, 8'd188, colorMarker);      // dx 21 dy 32
addCase("m0 grid corner",     3'd0, 9'd228, 8'd228, colorGrid);
addCase("m0 below board",     3'd0, 9'd100, 8'd235, colorBackground);

// map 1, blocks (1,4) and (4,2)
addCase("m1 m1 ring top",     3'd1, 9'd170, 8'd87,  colorMarker);
addCase("m1 m1 ring left",    3'd1, 9'd159, 8'd101, colorMarker);
addCase("m1 m1 ring centre",  3'd1, 9'd173, 8'd101, colorBackground);
addCase("m1 outside ring",    3'd1, 9'd50,  8'd173, colorBackground);  // dx 2
addCase("m1 m0 ring right",   3'd1, 9'd80,  8'd176, colorMarker);

// map 2, blocks (0,2) and (2,2)
addCase("m2 m0 ring top",     3'd2, 9'd26,  8'd87,  colorMarker);
addCase("m2 m1 ring top",     3'd2, 9'd105, 8'd87,  colorMarker);      // dx 21
addCase("m2 m0 ring arc",     3'd2, 9'd21,  8'd89,  colorMarker);      // dx 9 dy 5
addCase("m2 m1 ring arc",     3'd2, 9'd114, 8'd109, colorMarker);      // dx 30 dy 25
addCase("m2 old marker",      3'd2, 9'd26,  8'd123, colorBackground);

// map 3, blocks (5,5) and (5,2)
addCase("m3 m1 ring top",     3'd3, 9'd206, 8'd87,  colorMarker);
addCase("m3 m1 ring left",    3'd3, 9'd195, 8'd101, colorMarker);
addCase("m3 beside arc",      3'd3, 9'd205, 8'd195, colorBackground);  // dx 13 dy 3
addCase("m3 m0 diagonal",     3'd3, 9'd199, 8'd199, colorMarker);      // dx 7 dy 7
addCase("m3 m0 far diagonal", 3'd3, 9'd220, 8'd220, colorMarker);      // dx 28 dy 28

// map 4, blocks (1,3) and (2,0)
addCase("m4 m1 ring top",     3'd4, 9'd98,  8'd15,  colorMarker);
addCase("m4 m1 ring side",    3'd4, 9'd88,  8'd24,  colorMarker);      // dx 4 dy 12
addCase("m4 m0 ring side",    3'd4, 9'd79,  8'd133, colorMarker);      // dx 31 dy 13
addCase("m4 m0 ring left",    3'd4, 9'd51,  8'd137, colorMarker);
addCase("m4 m0 ring right",   3'd4, 9'd80,  8'd140, colorMarker);

// map 6 is empty, then back to map 0
addCase("m6 no marker a",     3'd6, 9'd26,  8'd123, colorBackground);
addCase("m6 no marker b",     3'd6, 9'd80,  8'd140, colorBackground);
addCase("m0 marker again",    3'd0, 9'd26,  8'd123, colorMarker);

// ==== sim/boardRendererTb.sv ====
module boardRendererTb
  import boardPkg::*;
();

  localparam int waitLimit = 80000;  // a bit more than one frame of 76800

  logic                   clk;
  logic                   reset;
  logic [mapSelWidth-1:0] mapSelect;
  logic [xWidth-1:0]      pixelX;
  logic [yWidth-1:0]      pixelY;
  logic                   pixelValid;
  logic                   frameStart;
  logic [colorWidth-1:0]  pixelColor;

  int mismatchCount;
  int timeoutCount;
  bit aborted;                           // set once a wait runs out

  // case table filled from renderCases.svh
  string                  caseName[$];
  logic [mapSelWidth-1:0] caseMap[$];
  logic [xWidth-1:0]      caseX[$];
  logic [yWidth-1:0]      caseY[$];
  logic [colorWidth-1:0]  caseColor[$];

  boardRenderer dut (
    .clk, .reset, .mapSelect,
    .pixelX, .pixelY, .pixelValid, .frameStart, .pixelColor
  );

  always #4 clk = ~clk;

  // drive and sample just after the rising edge
  task automatic nextCycle();
    @(posedge clk);
    #1;
  endtask

  task automatic checkColor(string name, logic [colorWidth-1:0] expected,
                            logic [colorWidth-1:0] actual);
    if (actual !== expected) begin
      mismatchCount++;
      $display("MISMATCH %s expected %0d actual %0d", name, expected, actual);
    end
  endtask

  task automatic checkCoord(string name, logic [xWidth-1:0] expX, logic [yWidth-1:0] expY,
                            logic [xWidth-1:0] actX, logic [yWidth-1:0] actY);
    if (actX !== expX || actY !== expY) begin
      mismatchCount++;
      $display("MISMATCH %s expected (%0d,%0d) actual (%0d,%0d)", name, expX, expY, actX, actY);
    end
  endtask

  task automatic checkFlag(string name, logic expected, logic actual);
    if (actual !== expected) begin
      mismatchCount++;
      $display("MISMATCH %s expected %0b actual %0b", name, expected, actual);
    end
  endtask

  task automatic addCase(string name, logic [mapSelWidth-1:0] map, logic [xWidth-1:0] x,
                         logic [yWidth-1:0] y, logic [colorWidth-1:0] color);
    caseName.push_back(name);
    caseMap.push_back(map);
    caseX.push_back(x);
    caseY.push_back(y);
    caseColor.push_back(color);
  endtask

  task automatic loadCases();
    `include "renderCases.svh"
  endtask

  task automatic waitFrameStart(output bit reached);
    int count;
    reached = 1'b0;
    count = 0;
    while (!reached && count < waitLimit) begin
      nextCycle();
      count++;
      reached = pixelValid && frameStart;
    end
    if (!reached) begin
      timeoutCount++;
      aborted = 1'b1;
      $display("no frame start seen within %0d cycles", waitLimit);
    end
  endtask

  task automatic waitPixel(logic [xWidth-1:0] x, logic [yWidth-1:0] y, output bit reached);
    int count;
    reached = 1'b0;
    count = 0;
    while (!reached && count < waitLimit) begin
      nextCycle();
      count++;
      reached = pixelValid && pixelX == x && pixelY == y;
    end
    if (!reached) begin
      timeoutCount++;
      aborted = 1'b1;
      $display("pixel (%0d,%0d) never came out within %0d cycles", x, y, waitLimit);
    end
  endtask

  // walk consecutive outputs from a start pixel and predict each wrap
  task automatic followScan(string name, logic [xWidth-1:0] startX, logic [yWidth-1:0] startY,
                            int steps);
    logic [xWidth-1:0] expX;
    logic [yWidth-1:0] expY;
    bit                reached;
    int                i;
    waitPixel(startX, startY, reached);
    if (reached) begin
      expX = startX;
      expY = startY;
      for (i = 0; i < steps; i++) begin
        if (expX == xWidth'(screenWidth - 1)) begin
          expX = '0;
          expY = (expY == yWidth'(screenHeight - 1)) ? '0 : expY + yWidth'(1);
        end else begin
          expX = expX + xWidth'(1);
        end
        nextCycle();
        checkFlag({name, " valid"}, 1'b1, pixelValid);
        checkCoord(name, expX, expY, pixelX, pixelY);
        checkFlag({name, " frame"}, expX == '0 && expY == '0, frameStart);  // origin only
      end
    end
  endtask

  task automatic runCases();
    logic [mapSelWidth-1:0] curMap;
    bit                     reached;
    int                     i;
    curMap = '0;                          // map latched by reset
    for (i = 0; i < caseName.size() && !aborted; i++) begin
      if (caseMap[i] != curMap) begin
        mapSelect = caseMap[i];
        curMap = caseMap[i];
        nextCycle();                      // frame start already in flight keeps old map
        waitFrameStart(reached);
      end
      if (!aborted) begin
        waitPixel(caseX[i], caseY[i], reached);
        if (reached) checkColor(caseName[i], caseColor[i], pixelColor);
      end
    end
  endtask

  // old map stays in force for the rest of the frame after a mid frame change
  task automatic switchMapMidFrame(logic [mapSelWidth-1:0] newMap, logic [xWidth-1:0] x,
                                   logic [yWidth-1:0] y, logic [colorWidth-1:0] oldColor);
    bit reached;
    mapSelect = newMap;
    waitPixel(x, y, reached);
    if (reached) checkColor("map held mid frame", oldColor, pixelColor);
  endtask

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    mapSelect = '0;
    mismatchCount = 0;
    timeoutCount = 0;
    aborted = 1'b0;
    loadCases();

    repeat (10) begin
      nextCycle();
      checkFlag("reset valid", 1'b0, pixelValid);
      checkFlag("reset frame", 1'b0, frameStart);
      checkColor("reset color", colorBackground, pixelColor);
    end
    reset = 1'b0;
    repeat (2) begin                      // pipeline still empty
      nextCycle();
      checkFlag("startup valid", 1'b0, pixelValid);
      checkFlag("startup frame", 1'b0, frameStart);
      checkColor("startup color", colorBackground, pixelColor);
    end
    nextCycle();
    checkFlag("first valid", 1'b1, pixelValid);  // first pixel is the origin
    checkFlag("first frame", 1'b1, frameStart);
    checkCoord("first pixel", '0, '0, pixelX, pixelY);

    followScan("row wrap", 9'd317, 8'd5, 6);
    if (!aborted) followScan("frame wrap", 9'd316, 8'd239, 8);
    if (!aborted) runCases();
    // last case left map 0 on screen at (26,123), its ring pixel (224,176) is still ahead
    if (!aborted) switchMapMidFrame(3'd6, 9'd224, 8'd176, colorMarker);

    $display("errors %0d mismatches %0d timeouts", mismatchCount, timeoutCount);
    if (mismatchCount == 0 && timeoutCount == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== boardRenderer.f ====
+incdir+sim
design/boardPkg.sv
design/pixelScanner.sv
design/markerMapRom.sv
design/circleMarker.sv
design/pixelComposer.sv
design/boardRenderer.sv
sim/boardRendererTb.sv

// ==== runSim.sh ====
#!/usr/bin/env bash
# build and run the board renderer testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary -Wno-fatal -f boardRenderer.f --top-module boardRendererTb \
    -Mdir obj_dir -o boardRendererSim; then
  echo "verilator build failed"
  exit 1
fi

simOutput=$(./obj_dir/boardRendererSim 2>&1)
simStatus=$?
echo "$simOutput"

if [ "$simStatus" -ne 0 ]; then
  echo "simulation exited with status $simStatus"
  exit 1
fi

if grep -qF "=== PASS ===" <<< "$simOutput"; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi
